// File: include/datapath_params.svh
`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

// data path word width
`define DATA_W 8

// memory address width and word count
`define ADDR_W 8
`define MEM_DEPTH 256

// instruction register holds two data bytes
`define IR_W 16

// O, N, C, Z
`define FLAG_W 4

`endif

// File: rtl/datapathPkg.sv
`include "datapath_params.svh"

package datapathPkg;

   typedef logic [`DATA_W-1:0] dataT;
   typedef logic [`ADDR_W-1:0] addrT;
   typedef logic [`IR_W-1:0]   instrT;

   // shared by every register in the datapath
   typedef enum logic [1:0] {
      regClear = 2'd0,
      regLoad  = 2'd1,
      regDec   = 2'd2,
      regInc   = 2'd3
   } regFunT;

   // one enable per register, bit 3 is the first register
   typedef logic [3:0] regSelT;

endpackage

// File: rtl/aluPkg.sv
`include "datapath_params.svh"

package aluPkg;

   typedef enum logic [3:0] {
      opPassA  = 4'd0,
      opPassB  = 4'd1,
      opNotA   = 4'd2,
      opNotB   = 4'd3,
      opAdd    = 4'd4,
      opSub    = 4'd5,
      opCmpSel = 4'd6,
      opAnd    = 4'd7,
      opOr     = 4'd8,
      opNand   = 4'd9,
      opXor    = 4'd10,
      opLsl    = 4'd11,
      opLsr    = 4'd12,
      opAsl    = 4'd13,
      opAsr    = 4'd14,
      opRor    = 4'd15
   } aluOpT;

   typedef logic [`FLAG_W-1:0] flagsT;

   // bit positions inside flagsT
   localparam int flagO = 0;
   localparam int flagN = 1;
   localparam int flagC = 2;
   localparam int flagZ = 3;

endpackage

// File: rtl/regFile.sv
`timescale 1ns/10ps

module regFile
   import datapathPkg::*;
(
   input  logic   clk,
   input  logic   arstN,
   input  dataT   load,
   input  logic [2:0] outASel,
   input  logic [2:0] outBSel,
   input  regFunT funSel,
   input  regSelT rSel,
   input  regSelT tSel,
   output dataT   aOut,
   output dataT   bOut
);

   dataT       regs [8];   // T1..T4 then R1..R4
   logic [7:0] en;

   // select bit 3 maps to the lowest index of each group
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         en[i]     = tSel[3-i];
         en[i + 4] = rSel[3-i];
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 8; i++) begin
            if (en[i]) begin
               case (funSel)
                  regClear: regs[i] <= '0;
                  regLoad:  regs[i] <= load;
                  regDec:   regs[i] <= regs[i] - dataT'(1);   // wraps at zero
                  regInc:   regs[i] <= regs[i] + dataT'(1);
                  default:  regs[i] <= regs[i];
               endcase
            end
         end
      end
   end

   assign aOut = regs[outASel];
   assign bOut = regs[outBSel];

   // a selected register must see a defined function
   assert property (@(posedge clk) disable iff (!arstN)
      (|{rSel, tSel}) |-> !$isunknown(funSel))
      else $error("regFile: funSel unknown with a register enabled");

endmodule

// File: rtl/addrRegFile.sv
`timescale 1ns/10ps

module addrRegFile
   import datapathPkg::*;
(
   input  logic       clk,
   input  logic       arstN,
   input  dataT       load,
   input  logic [1:0] outCSel,
   input  logic [1:0] outDSel,
   input  regFunT     funSel,
   input  regSelT     regSel,
   output dataT       outC,
   output addrT       outD
);

   dataT regs [4];   // AR, SP, PCP, PC

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 4; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (regSel[3-i]) begin   // bit 3 is AR
               case (funSel)
                  regClear: regs[i] <= '0;
                  regLoad:  regs[i] <= load;
                  regDec:   regs[i] <= regs[i] - dataT'(1);
                  regInc:   regs[i] <= regs[i] + dataT'(1);
                  default:  regs[i] <= regs[i];
               endcase
            end
         end
      end
   end

   assign outC = regs[outCSel];
   // port D drives the memory address
   assign outD = addrT'(regs[outDSel]);

endmodule

// File: rtl/instrReg.sv
`timescale 1ns/10ps
`include "datapath_params.svh"

module instrReg
   import datapathPkg::*;
(
   input  logic   clk,
   input  logic   arstN,
   input  dataT   data,
   input  logic   enable,
   input  logic   lh,
   input  regFunT funSel,
   output instrT  irOut
);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         irOut <= '0;
      end else if (enable) begin
         case (funSel)
            regClear: irOut <= '0;
            regLoad: begin
               // one byte per load, the other half holds
               if (!lh) begin
                  irOut[`DATA_W-1:0] <= data;
               end else begin
                  irOut[`IR_W-1:`DATA_W] <= data;
               end
            end
            regDec:  irOut <= irOut - instrT'(1);   // full 16 bits
            regInc:  irOut <= irOut + instrT'(1);
            default: irOut <= irOut;
         endcase
      end
   end

endmodule

// File: rtl/dataMemory.sv
`timescale 1ns/10ps
`include "datapath_params.svh"

module dataMemory
   import datapathPkg::*;
(
   input  logic clk,
   input  addrT address,
   input  dataT data,
   input  logic wr,
   input  logic cs,
   output dataT dataOut
);

   dataT mem [`MEM_DEPTH];

   initial begin
      for (int i = 0; i < `MEM_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // cs is active low, wr high writes
   always_ff @(posedge clk) begin
      if (!cs && wr) begin
         mem[address] <= data;
      end
   end

   assign dataOut = (!cs && !wr) ? mem[address] : '0;   // 0 when idle

   assert property (@(posedge clk) !cs |-> !$isunknown(address))
      else $error("dataMemory: address unknown while selected");

endmodule

// File: rtl/alu.sv
`timescale 1ns/10ps
`include "datapath_params.svh"

module alu
   import datapathPkg::*;
   import aluPkg::*;
(
   input  dataT  a,
   input  dataT  b,
   input  aluOpT op,
   output flagsT flags,
   output dataT  result
);

   localparam int msb = `DATA_W - 1;

   logic [`DATA_W:0] sum;
   logic [`DATA_W:0] diff;
   logic             subO;
   dataT             flagSrc;

   // no carry in
   assign sum  = {1'b0, a} + {1'b0, b};
   assign diff = {1'b0, a} + {1'b0, ~b} + (`DATA_W+1)'(1);

   // signs differ and the result left A's sign
   assign subO = (a[msb] ^ b[msb]) & (a[msb] ^ diff[msb]);

   always_comb begin
      result = '0;
      flags  = '0;
      case (op)
         opPassA: result = a;
         opPassB: result = b;
         opNotA:  result = ~a;
         opNotB:  result = ~b;
         opAdd: begin
            result       = sum[msb:0];
            flags[flagC] = sum[`DATA_W];
            flags[flagO] = (a[msb] & b[msb]) ^ sum[msb];
         end
         opSub: begin
            result       = diff[msb:0];
            flags[flagC] = diff[`DATA_W];
            flags[flagO] = subO;
         end
         opCmpSel: begin
            flags[flagC] = diff[`DATA_W];
            flags[flagO] = subO;
            // pass A when A > B in signed terms
            if (!subO && !diff[msb] && diff[msb:0] != '0) begin
               result = a;
            end else if (subO && !a[msb]) begin
               result = a;
            end
         end
         opAnd:  result = a & b;
         opOr:   result = a | b;
         opNand: result = ~(a & b);
         opXor:  result = a ^ b;
         opLsl: begin
            result       = {a[msb-1:0], 1'b0};
            flags[flagC] = a[msb];
         end
         opLsr: begin
            result       = {1'b0, a[msb:1]};
            flags[flagC] = a[0];
         end
         opAsl: begin
            result       = {a[msb-1:0], 1'b0};
            flags[flagO] = a[msb] ^ a[msb-1];   // sign change
         end
         opAsr:  result = {a[msb], a[msb:1]};
         opRor: begin
            result       = {a[0], a[msb:1]};
            flags[flagC] = a[0];
         end
         default: result = '0;
      endcase

      // compare flags describe the subtraction, not the output
      flagSrc      = (op == opCmpSel) ? diff[msb:0] : result;
      flags[flagZ] = (flagSrc == '0);
      flags[flagN] = (op == opAsr) ? 1'b0 : flagSrc[msb];
   end

endmodule

// File: rtl/aluSystem.sv
`timescale 1ns/10ps
`include "datapath_params.svh"

module aluSystem
   import datapathPkg::*;
   import aluPkg::*;
(
   input  logic       clk,
   input  logic       arstN,
   input  logic [1:0] ARF_OutCSel,
   input  logic [1:0] ARF_OutDSel,
   input  regFunT     IR_Funsel,
   input  regFunT     ARF_FunSel,
   input  regFunT     RF_FunSel,
   input  aluOpT      ALU_FunSel,
   input  regSelT     RF_RSel,
   input  regSelT     RF_TSel,
   input  regSelT     ARF_RegSel,
   input  logic       Mem_WR,
   input  logic       Mem_CS,
   input  logic       IR_Enable,
   input  logic       IR_LH,
   input  logic       MuxCSel,
   input  logic [1:0] MuxASel,
   input  logic [1:0] MuxBSel,
   input  logic [2:0] RF_OutASel,
   input  logic [2:0] RF_OutBSel,
   output dataT       AOut,
   output dataT       BOut,
   output dataT       ALUOut,
   output dataT       ARF_AOut,
   output dataT       Address,
   output dataT       MemoryOut,
   output dataT       MuxAOut,
   output dataT       MuxBOut,
   output dataT       MuxCOut,
   output flagsT      ALUOutFlag,
   output instrT      IROut
);

   // MuxA and MuxB share the same source order
   function automatic dataT srcSel(input logic [1:0] sel, input dataT aluV, input dataT memV,
                                   input dataT irV, input dataT arfV);
      case (sel)
         2'd0:    return aluV;
         2'd1:    return memV;
         2'd2:    return irV;
         default: return arfV;
      endcase
   endfunction

   assign MuxAOut = srcSel(MuxASel, ALUOut, MemoryOut, IROut[`DATA_W-1:0], ARF_AOut);
   assign MuxBOut = srcSel(MuxBSel, ALUOut, MemoryOut, IROut[`DATA_W-1:0], ARF_AOut);
   assign MuxCOut = MuxCSel ? ARF_AOut : AOut;

   regFile uRegFile (
      .clk(clk), .arstN(arstN), .load(MuxAOut),
      .outASel(RF_OutASel), .outBSel(RF_OutBSel), .funSel(RF_FunSel),
      .rSel(RF_RSel), .tSel(RF_TSel), .aOut(AOut), .bOut(BOut)
   );

   addrRegFile uAddrRegFile (
      .clk(clk), .arstN(arstN), .load(MuxBOut),
      .outCSel(ARF_OutCSel), .outDSel(ARF_OutDSel), .funSel(ARF_FunSel),
      .regSel(ARF_RegSel), .outC(ARF_AOut), .outD(Address)
   );

   instrReg uInstrReg (
      .clk(clk), .arstN(arstN), .data(MemoryOut), .enable(IR_Enable),
      .lh(IR_LH), .funSel(IR_Funsel), .irOut(IROut)
   );

   dataMemory uDataMemory (
      .clk(clk), .address(Address), .data(ALUOut),
      .wr(Mem_WR), .cs(Mem_CS), .dataOut(MemoryOut)
   );

   alu uAlu (
      .a(MuxCOut), .b(BOut), .op(ALU_FunSel), .flags(ALUOutFlag), .result(ALUOut)
   );

   // ALU result feeds both register loads and memory data
   assert property (@(posedge clk) disable iff (!arstN) !$isunknown(ALU_FunSel))
      else $error("aluSystem: ALU op unknown");

endmodule

// File: tests/aluSystemTb.sv
`timescale 1ns/10ps
`include "datapath_params.svh"

module aluSystemTb
   import datapathPkg::*;
   import aluPkg::*;
();

   localparam int numCycles    = 3000;
   localparam int msb          = `DATA_W - 1;

   logic       clk;
   logic       arstN;
   logic [1:0] ARF_OutCSel, ARF_OutDSel, MuxASel, MuxBSel;
   logic [2:0] RF_OutASel, RF_OutBSel;
   regFunT     IR_Funsel, ARF_FunSel, RF_FunSel;
   aluOpT      ALU_FunSel;
   regSelT     RF_RSel, RF_TSel, ARF_RegSel;
   logic       Mem_WR, Mem_CS, IR_Enable, IR_LH, MuxCSel;
   dataT       AOut, BOut, ALUOut, ARF_AOut, Address, MemoryOut;
   dataT       MuxAOut, MuxBOut, MuxCOut;
   flagsT      ALUOutFlag;
   instrT      IROut;

   // reference state
   dataT  rfModel [8];   // T1..T4, R1..R4
   dataT  arfModel [4];  // AR, SP, PCP, PC
   instrT irModel;
   dataT  memModel [`MEM_DEPTH];
   logic [31:0] rngState;

   dataT  expA, expB, expArf, expAddr, expMem, expMuxA, expMuxB, expMuxC, expAlu;
   flagsT expFlags;

   aluSystem DUT (
      .clk(clk), .arstN(arstN),
      .ARF_OutCSel(ARF_OutCSel), .ARF_OutDSel(ARF_OutDSel),
      .IR_Funsel(IR_Funsel), .ARF_FunSel(ARF_FunSel), .RF_FunSel(RF_FunSel),
      .ALU_FunSel(ALU_FunSel), .RF_RSel(RF_RSel), .RF_TSel(RF_TSel),
      .ARF_RegSel(ARF_RegSel), .Mem_WR(Mem_WR), .Mem_CS(Mem_CS),
      .IR_Enable(IR_Enable), .IR_LH(IR_LH), .MuxCSel(MuxCSel),
      .MuxASel(MuxASel), .MuxBSel(MuxBSel),
      .RF_OutASel(RF_OutASel), .RF_OutBSel(RF_OutBSel),
      .AOut(AOut), .BOut(BOut), .ALUOut(ALUOut), .ARF_AOut(ARF_AOut),
      .Address(Address), .MemoryOut(MemoryOut), .MuxAOut(MuxAOut),
      .MuxBOut(MuxBOut), .MuxCOut(MuxCOut), .ALUOutFlag(ALUOutFlag), .IROut(IROut)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stopOnError(input string reason);
      $display("*** FAILED ***");
      $display("%s", reason);
      $fatal(1);
   endtask

   task automatic compareValue(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
      if (got !== expected) begin
         stopOnError($sformatf("MISMATCH at %0t: %s got %h expected %h",
                               $time, name, got, expected));
      end
   endtask

   function automatic dataT applyRegFun(input dataT cur, input regFunT fun, input dataT ld);
      case (fun)
         regClear: return '0;
         regLoad:  return ld;
         regDec:   return cur - dataT'(1);
         default:  return cur + dataT'(1);
      endcase
   endfunction

   // 0 ALU, 1 memory, 2 IR low byte, 3 ARF port C
   function automatic dataT routeSource(input logic [1:0] sel);
      case (sel)
         2'd0:    return expAlu;
         2'd1:    return expMem;
         2'd2:    return irModel[msb:0];
         default: return expArf;
      endcase
   endfunction

   task automatic computeAlu(input dataT a, input dataT b, input aluOpT op,
                             output dataT res, output flagsT fl);
      logic [`DATA_W:0] wide;
      dataT diffV;
      dataT flagSrc;
      logic subOvf;
      logic ovf;
      logic cry;
      diffV  = a - b;
      subOvf = (a[msb] != b[msb]) && (diffV[msb] != a[msb]);
      wide   = {1'b0, a} + {1'b0, b};
      ovf    = 1'b0;
      cry    = 1'b0;
      res    = '0;
      case (op)
         opPassA: res = a;
         opPassB: res = b;
         opNotA:  res = ~a;
         opNotB:  res = ~b;
         opAdd: begin
            res = wide[msb:0];
            cry = wide[`DATA_W];
            ovf = (a[msb] & b[msb]) ^ res[msb];
         end
         opSub: begin
            res = diffV;
            cry = (a >= b);   // no borrow
            ovf = subOvf;
         end
         opCmpSel: begin
            cry = (a >= b);
            ovf = subOvf;
            if ((!subOvf && !diffV[msb] && diffV != '0) || (subOvf && !a[msb])) begin
               res = a;
            end
         end
         opAnd:  res = a & b;
         opOr:   res = a | b;
         opNand: res = ~(a & b);
         opXor:  res = a ^ b;
         opLsl: begin
            res = a << 1;
            cry = a[msb];
         end
         opLsr: begin
            res = a >> 1;
            cry = a[0];
         end
         opAsl: begin
            res = a << 1;
            ovf = a[msb] ^ res[msb];
         end
         opAsr:  res = dataT'($signed(a) >>> 1);
         opRor: begin
            res = {a[0], a[msb:1]};
            cry = a[0];
         end
         default: res = '0;
      endcase
      flagSrc   = (op == opCmpSel) ? diffV : res;   // compare reports the subtraction
      fl        = '0;
      fl[flagO] = ovf;
      fl[flagC] = cry;
      fl[flagZ] = (flagSrc == '0);
      fl[flagN] = (op == opAsr) ? 1'b0 : flagSrc[msb];
   endtask

   task automatic computeExpected();
      expA    = rfModel[RF_OutASel];
      expB    = rfModel[RF_OutBSel];
      expArf  = arfModel[ARF_OutCSel];
      expAddr = arfModel[ARF_OutDSel];
      expMem  = (!Mem_CS && !Mem_WR) ? memModel[expAddr] : '0;
      expMuxC = MuxCSel ? expArf : expA;
      computeAlu(expMuxC, expB, ALU_FunSel, expAlu, expFlags);
      expMuxA = routeSource(MuxASel);
      expMuxB = routeSource(MuxBSel);
   endtask

   task automatic checkOutputs();
      compareValue("AOut", 16'(AOut), 16'(expA));
      compareValue("BOut", 16'(BOut), 16'(expB));
      compareValue("ARF_AOut", 16'(ARF_AOut), 16'(expArf));
      compareValue("Address", 16'(Address), 16'(expAddr));
      compareValue("MemoryOut", 16'(MemoryOut), 16'(expMem));
      compareValue("MuxCOut", 16'(MuxCOut), 16'(expMuxC));
      compareValue("ALUOut", 16'(ALUOut), 16'(expAlu));
      compareValue("ALUOutFlag", 16'(ALUOutFlag), 16'(expFlags));
      compareValue("MuxAOut", 16'(MuxAOut), 16'(expMuxA));
      compareValue("MuxBOut", 16'(MuxBOut), 16'(expMuxB));
      compareValue("IROut", IROut, irModel);
   endtask

   // called right after the rising edge, inputs still hold the old values
   task automatic updateModel();
      for (int i = 0; i < 4; i++) begin
         if (RF_TSel[3-i]) begin
            rfModel[i] = applyRegFun(rfModel[i], RF_FunSel, expMuxA);
         end
         if (RF_RSel[3-i]) begin
            rfModel[i+4] = applyRegFun(rfModel[i+4], RF_FunSel, expMuxA);
         end
         if (ARF_RegSel[3-i]) begin
            arfModel[i] = applyRegFun(arfModel[i], ARF_FunSel, expMuxB);
         end
      end
      if (!Mem_CS && Mem_WR) begin
         memModel[expAddr] = expAlu;
      end
      if (IR_Enable) begin
         case (IR_Funsel)
            regClear: irModel = '0;
            regLoad: begin
               if (IR_LH) begin
                  irModel[`IR_W-1:`DATA_W] = expMem;
               end else begin
                  irModel[msb:0] = expMem;
               end
            end
            regDec:   irModel = irModel - instrT'(1);
            default:  irModel = irModel + instrT'(1);
         endcase
      end
   endtask

   task automatic driveRandomInputs();
      logic [31:0] r1;
      logic [31:0] r2;
      rngState = xorshift32(rngState);
      r1 = rngState;
      rngState = xorshift32(rngState);
      r2 = rngState;
      RF_FunSel   <= regFunT'(r1[1:0]);
      ARF_FunSel  <= regFunT'(r1[3:2]);
      IR_Funsel   <= regFunT'(r1[5:4]);
      ALU_FunSel  <= aluOpT'(r1[9:6]);
      RF_RSel     <= r1[13:10];
      RF_TSel     <= r1[17:14];
      ARF_RegSel  <= r1[21:18] & r2[12:9];   // sparse, keeps addresses around longer
      ARF_OutCSel <= r1[23:22];
      ARF_OutDSel <= r1[25:24];
      RF_OutASel  <= r1[28:26];
      RF_OutBSel  <= r1[31:29];
      Mem_WR      <= r2[0];
      Mem_CS      <= r2[1];
      IR_Enable   <= r2[2];
      IR_LH       <= r2[3];
      MuxCSel     <= r2[4];
      MuxASel     <= r2[6:5];
      MuxBSel     <= r2[8:7];
   endtask

   initial begin
      rngState    = 32'hf58f;
      arstN       = 1'b0;
      RF_FunSel   = regClear;
      ARF_FunSel  = regClear;
      IR_Funsel   = regClear;
      ALU_FunSel  = opPassA;
      RF_RSel     = '0;
      RF_TSel     = '0;
      ARF_RegSel  = '0;
      ARF_OutCSel = '0;
      ARF_OutDSel = '0;
      RF_OutASel  = '0;
      RF_OutBSel  = '0;
      Mem_WR      = 1'b0;
      Mem_CS      = 1'b1;   // memory idle
      IR_Enable   = 1'b0;
      IR_LH       = 1'b0;
      MuxCSel     = 1'b0;
      MuxASel     = '0;
      MuxBSel     = '0;
      for (int i = 0; i < 8; i++) begin
         rfModel[i] = '0;
      end
      for (int i = 0; i < 4; i++) begin
         arfModel[i] = '0;
      end
      for (int i = 0; i < `MEM_DEPTH; i++) begin
         memModel[i] = '0;
      end
      irModel = '0;

      for (int i = 0; i < 2; i++) begin
         @(posedge clk);
      end
      arstN <= 1'b1;
      driveRandomInputs();
      @(negedge clk);

      // every register comes out of reset at zero
      compareValue("AOut", 16'(AOut), 16'h0);
      compareValue("BOut", 16'(BOut), 16'h0);
      compareValue("ARF_AOut", 16'(ARF_AOut), 16'h0);
      compareValue("Address", 16'(Address), 16'h0);
      compareValue("IROut", IROut, 16'h0);

      for (int cyc = 0; cyc < numCycles; cyc++) begin
         computeExpected();
         checkOutputs();
         @(posedge clk);
         updateModel();
         driveRandomInputs();
         @(negedge clk);
      end

      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: sim.f
+incdir+include
rtl/datapathPkg.sv
rtl/aluPkg.sv
rtl/regFile.sv
rtl/addrRegFile.sv
rtl/instrReg.sv
rtl/dataMemory.sv
rtl/alu.sv
rtl/aluSystem.sv
tests/aluSystemTb.sv

// File: Makefile
# Verilator build and run of the datapath testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module aluSystemTb -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
